//--- design/drm_params.svh
// Input writer parameters
`ifndef DRM_PARAMS_SVH
`define DRM_PARAMS_SVH

// Users and buffer geometry
`define DRM_USERS       8
`define DRM_LANES       16
`define DRM_LANE_W      48
`define DRM_RX_W        96

// Position and address widths
`define DRM_POS_W       14
`define DRM_ROW_W       10
`define DRM_ADDR_W      11    // Ping-pong bit plus row

// Configuration field widths
`define DRM_SZ_W        16
`define DRM_CB_W        8
`define DRM_QM_W        4

// Start sequencer walks counts 0 to this value
`define DRM_SETUP_LAST  8

`endif

//--- design/drm_pkg.sv
// Input writer types
`include "drm_params.svh"

package drm_pkg;

	// Buffer position, read flat for counting and split for addressing
	typedef union packed {
		logic [`DRM_POS_W-1:0] flat;
		struct packed {
			logic [`DRM_ROW_W-1:0]             row;
			logic [`DRM_POS_W-`DRM_ROW_W-1:0] lane;
		} split;
	} buf_pos_u;

	typedef logic [`DRM_POS_W-1:0] re_cnt_t;    // RE counter
	typedef logic [`DRM_SZ_W-1:0]  sz_t;        // E0/E1 size
	typedef logic [`DRM_CB_W-1:0]  cb_cnt_t;    // Code-block count
	typedef logic [`DRM_QM_W-1:0]  qm_t;        // Modulation order

	// One spare bit so out-of-range indices can be seen
	typedef logic [$clog2(`DRM_USERS):0] user_idx_t;

endpackage

//--- design/drm_start_calc.sv
// Slot start sequencer
`timescale 1ns/1ps
`include "drm_params.svh"

module drm_start_calc
	import drm_pkg::*;
(
	input  logic                        i_core_clk,
	input  logic                        i_rx_rstn,
	input  logic                        i_rdm_slot_start,
	input  sz_t      [`DRM_USERS-1:0]   i_e1_sz,
	output buf_pos_u [`DRM_USERS-1:0]   o_start,
	output logic                        o_start_load
);

	localparam int CNT_W     = $clog2(`DRM_SETUP_LAST + 2);
	localparam int IDX_W     = $clog2(`DRM_USERS);
	localparam int LANE_BITS = $clog2(`DRM_LANES);
	localparam logic [CNT_W-1:0] LAST    = CNT_W'(`DRM_SETUP_LAST);
	localparam logic [CNT_W-1:0] IDLE    = LAST + 1'b1;
	localparam logic [CNT_W-1:0] N_USERS = CNT_W'(`DRM_USERS);

	logic [CNT_W-1:0]               setup_cnt;
	logic [IDX_W-1:0]               user_idx;
	logic [`DRM_SZ_W-LANE_BITS-1:0] e1_rows;
	buf_pos_u                       run_sum;
	buf_pos_u                       base;
	buf_pos_u                       region;

	assign user_idx = setup_cnt[IDX_W-1:0];
	assign e1_rows  = i_e1_sz[user_idx][`DRM_SZ_W-1:LANE_BITS] + 1'b1;    // Round up to full rows
	assign base     = (setup_cnt == '0) ? '0 : run_sum;

	always_comb
	begin
		region.split.row  = e1_rows[`DRM_ROW_W-1:0];
		region.split.lane = '0;
	end

	////////////////////////////////////////////////////////////
	// Setup count, parked at IDLE until a slot start
	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
			setup_cnt <= IDLE;
		else if (i_rdm_slot_start)
			setup_cnt <= '0;
		else if (setup_cnt <= LAST)
			setup_cnt <= setup_cnt + 1'b1;
	end

	// Running sum of regions, latched per user
	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			run_sum <= '0;
			o_start <= '0;
		end
		else if (setup_cnt < N_USERS)
		begin
			run_sum.flat      <= base.flat + region.flat;
			o_start[user_idx] <= base;
		end
	end

	assign o_start_load = (setup_cnt == LAST);    // All starts valid here

endmodule

//--- design/drm_user_track.sv
// Per-user RE tracker
`timescale 1ns/1ps
`include "drm_params.svh"

module drm_user_track
	import drm_pkg::*;
(
	input  logic     i_core_clk,
	input  logic     i_rx_rstn,
	input  logic     i_rdm_slot_start,
	input  logic     i_start_load,
	input  buf_pos_u i_start,
	input  logic     i_sel,          // Strobe for this user
	input  logic     i_two_layer,
	input  sz_t      i_e0_sz,
	input  sz_t      i_e1_sz,
	input  cb_cnt_t  i_e0_num,
	output buf_pos_u o_pos,
	output logic     o_pingpong,
	output logic     o_cb_done,
	output re_cnt_t  o_cb_len
);

	re_cnt_t re_cnt;
	cb_cnt_t cb_cnt;
	sz_t     limit;
	re_cnt_t step;
	logic    below;
	logic    cb_end;

	// E0 size for the first code blocks, E1 after that
	assign limit  = (cb_cnt < i_e0_num) ? i_e0_sz : i_e1_sz;
	assign step   = i_two_layer ? re_cnt_t'(2) : re_cnt_t'(1);
	assign below  = {{(`DRM_SZ_W-`DRM_POS_W){1'b0}}, re_cnt} < limit;
	assign cb_end = i_sel && !i_rdm_slot_start && !below;

	////////////////////////////////////////////////////////////
	// RE counter, code-block count and ping-pong half
	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			re_cnt     <= '0;
			cb_cnt     <= '0;
			o_pingpong <= 1'b0;
		end
		else if (i_rdm_slot_start)
		begin
			re_cnt <= '0;    // Ping-pong carries over
			cb_cnt <= '0;
		end
		else if (i_sel)
		begin
			if (below)
				re_cnt <= re_cnt + step;
			else
			begin
				re_cnt     <= '0;
				cb_cnt     <= cb_cnt + cb_cnt_t'(1);
				o_pingpong <= ~o_pingpong;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Buffer position
	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
			o_pos <= '0;
		else if (i_start_load)
			o_pos <= i_start;
		else if (i_sel)
		begin
			if (below)
				o_pos.flat <= o_pos.flat + step;
			else
				o_pos <= i_start;    // Next code block reuses the region
		end
	end

	// End flag and length in the strobe cycle
	assign o_cb_done = cb_end;
	assign o_cb_len  = re_cnt;

endmodule

//--- design/drm_write_port.sv
// Buffer write port
`timescale 1ns/1ps
`include "drm_params.svh"

module drm_write_port
	import drm_pkg::*;
(
	input  logic                                 i_core_clk,
	input  logic                                 i_rx_rstn,
	input  logic                                 i_demux_strb,
	input  user_idx_t                            i_demux_user_idx,
	input  logic [`DRM_RX_W-1:0]                 i_demux_rx,
	input  logic [`DRM_USERS-1:0]                i_layer_indicator,
	input  qm_t      [`DRM_USERS-1:0]            i_users_qm,
	input  buf_pos_u [`DRM_USERS-1:0]            i_pos,
	input  logic [`DRM_USERS-1:0]                i_pingpong,
	input  logic [`DRM_USERS-1:0]                i_cb_done,
	input  re_cnt_t  [`DRM_USERS-1:0]            i_cb_len,
	output logic [`DRM_USERS-1:0]                o_user_sel,
	output logic [`DRM_ADDR_W-1:0]               o_buf_wr_addr,
	output logic [`DRM_LANES-1:0]                o_buf_wr_en,
	output logic [`DRM_LANES*`DRM_LANE_W-1:0]    o_buf_wr_data,
	output logic                                 o_cb_done,
	output user_idx_t                            o_cb_user,
	output re_cnt_t                              o_cb_len
);

	localparam int IDX_W = $clog2(`DRM_USERS);
	localparam int LW    = `DRM_LANE_W;

	logic                 user_ok;
	logic [IDX_W-1:0]     uidx;
	buf_pos_u             pos_sel;
	logic                 two_sel;
	logic [5:0]           half_w;
	logic [LW-1:0]        half_mask;
	logic [`DRM_RX_W-1:0] rx_hi;
	logic [2*LW-1:0]      pair;
	user_idx_t            cb_idx;

	assign user_ok = (i_demux_user_idx < user_idx_t'(`DRM_USERS));
	assign uidx    = i_demux_user_idx[IDX_W-1:0];
	assign pos_sel = i_pos[uidx];
	assign two_sel = i_layer_indicator[uidx];

	////////////////////////////////////////////////////////////
	// User select, address and lane enables
	always_comb
	begin
		o_user_sel = '0;
		if (i_demux_strb && user_ok)
			o_user_sel[uidx] = 1'b1;
	end

	assign o_buf_wr_addr = user_ok ? {i_pingpong[uidx], pos_sel.split.row} : '1;

	always_comb
	begin
		o_buf_wr_en = '0;
		if (|o_user_sel)
		begin
			if (two_sel)
				o_buf_wr_en[{pos_sel.split.lane[3:1], 1'b0} +: 2] = 2'b11;
			else
				o_buf_wr_en[pos_sel.split.lane] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Data packing
	always_comb
	begin
		case (i_users_qm[uidx])
			4'd1:    half_w = 6'd6;
			4'd2:    half_w = 6'd12;
			4'd4:    half_w = 6'd24;
			4'd6:    half_w = 6'd36;
			4'd8:    half_w = 6'd48;
			default: half_w = 6'd0;    // Gives an all-zero pair
		endcase
	end

	assign half_mask = ~({LW{1'b1}} << half_w);
	assign rx_hi     = i_demux_rx >> half_w;
	assign pair      = {rx_hi[LW-1:0] & half_mask, i_demux_rx[LW-1:0] & half_mask};

	assign o_buf_wr_data = two_sel ? {(`DRM_LANES/2){pair}}
		: {`DRM_LANES{i_demux_rx[LW-1:0]}};

	////////////////////////////////////////////////////////////
	// Code-block report, lowest user wins
	always_comb
	begin
		cb_idx = '0;
		for (int u = `DRM_USERS - 1; u >= 0; u--)
		begin
			if (i_cb_done[u])
				cb_idx = user_idx_t'(u);
		end
	end

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
			o_cb_done <= 1'b0;
		else
			o_cb_done <= |i_cb_done;
	end

	always_ff @(posedge i_core_clk)
	begin
		if (|i_cb_done)
		begin
			o_cb_user <= cb_idx;
			o_cb_len  <= i_cb_len[cb_idx[IDX_W-1:0]];
		end
	end

endmodule

//--- design/drm_input_writer.sv
// Input buffer write side
`timescale 1ns/1ps
`include "drm_params.svh"

module drm_input_writer
	import drm_pkg::*;
(
	input  logic                                 i_core_clk,
	input  logic                                 i_rx_rstn,
	input  logic                                 i_rdm_slot_start,
	input  sz_t      [`DRM_USERS-1:0]            i_user_cfg_e0_sz,
	input  sz_t      [`DRM_USERS-1:0]            i_user_cfg_e1_sz,
	input  cb_cnt_t  [`DRM_USERS-1:0]            i_users_e0_num,
	input  logic [`DRM_USERS-1:0]                i_layer_indicator,
	input  qm_t      [`DRM_USERS-1:0]            i_users_qm,
	input  logic                                 i_demux_strb,
	input  user_idx_t                            i_demux_user_idx,
	input  logic [`DRM_RX_W-1:0]                 i_demux_rx,
	output logic [`DRM_ADDR_W-1:0]               o_buf_wr_addr,
	output logic [`DRM_LANES-1:0]                o_buf_wr_en,
	output logic [`DRM_LANES*`DRM_LANE_W-1:0]    o_buf_wr_data,
	output logic [`DRM_USERS-1:0]                o_pingpong,
	output logic                                 o_cb_done,
	output user_idx_t                            o_cb_user,
	output re_cnt_t                              o_cb_len
);

	buf_pos_u [`DRM_USERS-1:0] start;
	buf_pos_u [`DRM_USERS-1:0] pos;
	logic                      start_load;
	logic [`DRM_USERS-1:0]     user_sel;
	logic [`DRM_USERS-1:0]     cb_done;
	re_cnt_t  [`DRM_USERS-1:0] cb_len;

	drm_start_calc i_start_calc (
		.i_core_clk       (i_core_clk),
		.i_rx_rstn        (i_rx_rstn),
		.i_rdm_slot_start (i_rdm_slot_start),
		.i_e1_sz          (i_user_cfg_e1_sz),
		.o_start          (start),
		.o_start_load     (start_load)
	);

	////////////////////////////////////////////////////////////
	// One tracker per user
	genvar u;
	generate
		for (u = 0; u < `DRM_USERS; u = u + 1)
		begin : g_track
			drm_user_track i_track (
				.i_core_clk       (i_core_clk),
				.i_rx_rstn        (i_rx_rstn),
				.i_rdm_slot_start (i_rdm_slot_start),
				.i_start_load     (start_load),
				.i_start          (start[u]),
				.i_sel            (user_sel[u]),
				.i_two_layer      (i_layer_indicator[u]),
				.i_e0_sz          (i_user_cfg_e0_sz[u]),
				.i_e1_sz          (i_user_cfg_e1_sz[u]),
				.i_e0_num         (i_users_e0_num[u]),
				.o_pos            (pos[u]),
				.o_pingpong       (o_pingpong[u]),
				.o_cb_done        (cb_done[u]),
				.o_cb_len         (cb_len[u])
			);
		end
	endgenerate

	drm_write_port i_write_port (
		.i_core_clk        (i_core_clk),
		.i_rx_rstn         (i_rx_rstn),
		.i_demux_strb      (i_demux_strb),
		.i_demux_user_idx  (i_demux_user_idx),
		.i_demux_rx        (i_demux_rx),
		.i_layer_indicator (i_layer_indicator),
		.i_users_qm        (i_users_qm),
		.i_pos             (pos),
		.i_pingpong        (o_pingpong),
		.i_cb_done         (cb_done),
		.i_cb_len          (cb_len),
		.o_user_sel        (user_sel),
		.o_buf_wr_addr     (o_buf_wr_addr),
		.o_buf_wr_en       (o_buf_wr_en),
		.o_buf_wr_data     (o_buf_wr_data),
		.o_cb_done         (o_cb_done),
		.o_cb_user         (o_cb_user),
		.o_cb_len          (o_cb_len)
	);

endmodule

//--- sim/drm_input_writer_sva.sv
// Input writer assertions
`timescale 1ns/1ps
`include "drm_params.svh"

module drm_input_writer_sva
	import drm_pkg::*;
(
	input logic                    i_core_clk,
	input logic                    i_rx_rstn,
	input logic                    i_demux_strb,
	input logic [`DRM_LANES-1:0]   i_buf_wr_en,
	input logic                    i_start_load,
	input logic [`DRM_USERS-1:0]   i_pingpong
);

	localparam logic [`DRM_LANES-1:0] EVEN = {(`DRM_LANES/2){2'b01}};
	localparam logic [`DRM_LANES-1:0] ODD  = {(`DRM_LANES/2){2'b10}};

	logic pair_ok;
	int   fail_cnt = 0;    // Failed assertions so far

	// Both bits inside one aligned lane pair
	assign pair_ok = ($countones(i_buf_wr_en) == 2) &&
		(((i_buf_wr_en & EVEN) << 1) == (i_buf_wr_en & ODD));

	a_en_idle: assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		!i_demux_strb |-> (i_buf_wr_en == '0))
		else
		begin
			fail_cnt++;
			$error("Write enables active without a strobe");
		end

	a_en_shape: assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		(i_buf_wr_en == '0) || $onehot(i_buf_wr_en) || pair_ok)
		else
		begin
			fail_cnt++;
			$error("Write enables neither one lane nor an aligned pair");
		end

	a_load_pulse: assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		i_start_load |=> !i_start_load)
		else
		begin
			fail_cnt++;
			$error("Start load held longer than one cycle");
		end

	a_ping_strb: assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
		!$stable(i_pingpong) |-> $past(i_demux_strb))
		else
		begin
			fail_cnt++;
			$error("Ping-pong bits changed without a strobe");
		end

endmodule

bind drm_input_writer drm_input_writer_sva i_sva (
	.i_core_clk   (i_core_clk),
	.i_rx_rstn    (i_rx_rstn),
	.i_demux_strb (i_demux_strb),
	.i_buf_wr_en  (o_buf_wr_en),
	.i_start_load (start_load),
	.i_pingpong   (o_pingpong)
);

//--- sim/tb_drm_input_writer.sv
// Input writer testbench
`timescale 1ns/1ps
`include "drm_params.svh"

module tb_drm_input_writer
	import drm_pkg::*;
();

	localparam int    LW       = `DRM_LANE_W;
	localparam int    DATA_W   = `DRM_LANES * `DRM_LANE_W;
	localparam string VEC_FILE = "sim/drm_input_vectors.txt";

	typedef struct {
		byte                    kind;
		user_idx_t              user;
		int                     cnt;
		logic [`DRM_RX_W-1:0]   rx;
		logic [`DRM_ADDR_W-1:0] addr;
		logic [`DRM_LANES-1:0]  en;
		sz_t                    e0;
		sz_t                    e1;
		cb_cnt_t                num;
		logic                   two;
		qm_t                    qm;
	} vec_rec_t;

	logic                          core_clk;
	logic                          rx_rstn;
	logic                          rdm_slot_start;
	sz_t      [`DRM_USERS-1:0]     e0_sz;
	sz_t      [`DRM_USERS-1:0]     e1_sz;
	cb_cnt_t  [`DRM_USERS-1:0]     e0_num;
	logic     [`DRM_USERS-1:0]     layer;
	qm_t      [`DRM_USERS-1:0]     users_qm;
	logic                          demux_strb;
	user_idx_t                     demux_user_idx;
	logic [`DRM_RX_W-1:0]          demux_rx;
	logic [`DRM_ADDR_W-1:0]        buf_wr_addr;
	logic [`DRM_LANES-1:0]         buf_wr_en;
	logic [DATA_W-1:0]             buf_wr_data;
	logic [`DRM_USERS-1:0]         pingpong;
	logic                          cb_done;
	user_idx_t                     cb_user;
	re_cnt_t                       cb_len;

	// Reference model of the trackers
	re_cnt_t               model_re [`DRM_USERS];
	cb_cnt_t               model_cb [`DRM_USERS];
	logic [`DRM_USERS-1:0] model_ping;
	logic                  pend_done;
	user_idx_t             pend_user;
	re_cnt_t               pend_len;

	vec_rec_t recs[$];
	int       err_addr;
	int       err_en;
	int       err_data;
	int       err_cb;
	int       err_ping;
	int       err_other;
	int       cycle_cnt;
	int       cycle_limit;
	logic     limit_set = 1'b0;

	drm_input_writer i_dut (
		.i_core_clk       (core_clk),
		.i_rx_rstn        (rx_rstn),
		.i_rdm_slot_start (rdm_slot_start),
		.i_user_cfg_e0_sz (e0_sz),
		.i_user_cfg_e1_sz (e1_sz),
		.i_users_e0_num   (e0_num),
		.i_layer_indicator(layer),
		.i_users_qm       (users_qm),
		.i_demux_strb     (demux_strb),
		.i_demux_user_idx (demux_user_idx),
		.i_demux_rx       (demux_rx),
		.o_buf_wr_addr    (buf_wr_addr),
		.o_buf_wr_en      (buf_wr_en),
		.o_buf_wr_data    (buf_wr_data),
		.o_pingpong       (pingpong),
		.o_cb_done        (cb_done),
		.o_cb_user        (cb_user),
		.o_cb_len         (cb_len)
	);

	initial
	begin
		core_clk = 1'b0;
		forever #10 core_clk = ~core_clk;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic addr_compare(input string name, input logic [`DRM_ADDR_W-1:0] exp);
		if (buf_wr_addr !== exp)
		begin
			err_addr++;
			$display("Mismatch %s address: expected %h, actual %h", name, exp, buf_wr_addr);
		end
	endtask

	task automatic en_compare(input string name, input logic [`DRM_LANES-1:0] exp);
		if (buf_wr_en !== exp)
		begin
			err_en++;
			$display("Mismatch %s enables: expected %h, actual %h", name, exp, buf_wr_en);
		end
	endtask

	task automatic data_compare(input string name, input logic [DATA_W-1:0] exp);
		if (buf_wr_data !== exp)
		begin
			err_data++;
			$display("Mismatch %s data: expected %h, actual %h", name, exp, buf_wr_data);
		end
	endtask

	task automatic report_compare(input string name, input logic exp_done,
		input user_idx_t exp_user, input re_cnt_t exp_len);
		if (cb_done !== exp_done || (exp_done && (cb_user !== exp_user || cb_len !== exp_len)))
		begin
			err_cb++;
			$display("Mismatch %s cb report: expected %b/%0d/%0d, actual %b/%0d/%0d", name,
				exp_done, exp_user, exp_len, cb_done, cb_user, cb_len);
		end
	endtask

	task automatic pingpong_compare(input string name, input logic [`DRM_USERS-1:0] exp);
		if (pingpong !== exp)
		begin
			err_ping++;
			$display("Mismatch %s pingpong: expected %b, actual %b", name, exp, pingpong);
		end
	endtask

	// One layer copies the low lane and two layers split the qm bits into a pair
	function automatic logic [DATA_W-1:0] expected_data(input user_idx_t u,
		input logic [`DRM_RX_W-1:0] rx);
		logic [DATA_W-1:0] d;
		logic [LW-1:0]     lo;
		logic [LW-1:0]     hi;
		int                hw;
		d  = '0;
		lo = '0;
		hi = '0;
		case (users_qm[u[2:0]])
			4'd1:    hw = 6;
			4'd2:    hw = 12;
			4'd4:    hw = 24;
			4'd6:    hw = 36;
			4'd8:    hw = 48;
			default: hw = 0;
		endcase
		for (int b = 0; b < hw; b++)
		begin
			lo[b] = rx[b];
			hi[b] = rx[hw + b];
		end
		for (int l = 0; l < `DRM_LANES; l++)
		begin
			if (!layer[u[2:0]])
				d[l*LW +: LW] = rx[LW-1:0];
			else if (l % 2 == 0)
				d[l*LW +: LW] = lo;
			else
				d[l*LW +: LW] = hi;
		end
		return d;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks at the falling edge and model update for this cycle
	task automatic close_cycle(input string name, input logic strb, input logic slot,
		input user_idx_t u, input logic [`DRM_RX_W-1:0] rx,
		input logic [`DRM_ADDR_W-1:0] exp_addr, input logic [`DRM_LANES-1:0] exp_en);
		logic [2:0] k;
		sz_t        lim;
		re_cnt_t    step;
		k = u[2:0];
		report_compare(name, pend_done, pend_user, pend_len);
		pingpong_compare(name, model_ping);
		pend_done = 1'b0;
		if (slot)
		begin
			for (int i = 0; i < `DRM_USERS; i++)
			begin
				model_re[i] = '0;
				model_cb[i] = '0;
			end
		end
		if (!strb)
			en_compare(name, '0);
		else
		begin
			addr_compare(name, exp_addr);
			en_compare(name, exp_en);
			if (u < user_idx_t'(`DRM_USERS))
			begin
				data_compare(name, expected_data(u, rx));
				lim  = (model_cb[k] < e0_num[k]) ? e0_sz[k] : e1_sz[k];
				step = layer[k] ? re_cnt_t'(2) : re_cnt_t'(1);
				if (sz_t'(model_re[k]) < lim)
					model_re[k] = model_re[k] + step;
				else
				begin
					pend_done     = 1'b1;    // Report lands one cycle later
					pend_user     = u;
					pend_len      = model_re[k];
					model_re[k]   = '0;
					model_cb[k]   = model_cb[k] + cb_cnt_t'(1);
					model_ping[k] = ~model_ping[k];
				end
			end
		end
	endtask

	task automatic run_cycle(input string name, input logic strb, input logic slot,
		input user_idx_t u, input logic [`DRM_RX_W-1:0] rx,
		input logic [`DRM_ADDR_W-1:0] exp_addr, input logic [`DRM_LANES-1:0] exp_en);
		@(posedge core_clk);
		demux_strb     <= strb;
		rdm_slot_start <= slot;
		demux_user_idx <= u;
		demux_rx       <= rx;
		@(negedge core_clk);
		close_cycle(name, strb, slot, u, rx, exp_addr, exp_en);
	endtask

	task automatic apply_config(input string name, input vec_rec_t rec);
		@(posedge core_clk);
		e0_sz[rec.user[2:0]]    <= rec.e0;
		e1_sz[rec.user[2:0]]    <= rec.e1;
		e0_num[rec.user[2:0]]   <= rec.num;
		layer[rec.user[2:0]]    <= rec.two;
		users_qm[rec.user[2:0]] <= rec.qm;
		demux_strb              <= 1'b0;
		rdm_slot_start          <= 1'b0;
		@(negedge core_clk);
		close_cycle(name, 1'b0, 1'b0, '0, '0, '0, '0);
	endtask

	task automatic read_vectors();
		int                fd;
		int                n;
		logic [7:0]        tag;
		logic [8*160-1:0]  skip;
		vec_rec_t          rec;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0)
		begin
			err_other++;
			$display("Cannot open vector file %s", VEC_FILE);
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1)
		begin
			rec      = '{default: '0};
			rec.kind = tag;
			n        = 0;
			case (tag)
				"#":     n = $fgets(skip, fd);
				"C":     n = $fscanf(fd, "%h %h %h %h %h %h", rec.user, rec.e0, rec.e1,
					rec.num, rec.two, rec.qm);
				"P":     n = 0;
				"W":     n = $fscanf(fd, "%d", rec.cnt);
				"S":     n = $fscanf(fd, "%h %h %h %h", rec.user, rec.rx, rec.addr, rec.en);
				default:
				begin
					err_other++;
					$display("Unknown record tag %c in vector file", tag);
				end
			endcase
			if ((tag == "C" && n != 6) || (tag == "W" && n != 1) || (tag == "S" && n != 4))
			begin
				err_other++;
				$display("Malformed %c record in vector file", tag);
			end
			if (tag inside {"C", "P", "W", "S"})
				recs.push_back(rec);
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	initial
	begin : main
		string name;
		int    total;
		int    sva_fails;
		rx_rstn        = 1'b0;
		rdm_slot_start = 1'b0;
		e0_sz          = '0;
		e1_sz          = '0;
		e0_num         = '0;
		layer          = '0;
		users_qm       = '0;
		demux_strb     = 1'b0;
		demux_user_idx = '0;
		demux_rx       = '0;
		model_ping     = '0;
		pend_done      = 1'b0;
		pend_user      = '0;
		pend_len       = '0;
		err_addr       = 0;
		err_en         = 0;
		err_data       = 0;
		err_cb         = 0;
		err_ping       = 0;
		err_other      = 0;
		for (int i = 0; i < `DRM_USERS; i++)
		begin
			model_re[i] = '0;
			model_cb[i] = '0;
		end
		read_vectors();
		cycle_limit = 20 * recs.size() + 200;
		limit_set   = 1'b1;
		repeat (3) @(posedge core_clk);
		rx_rstn <= 1'b1;
		foreach (recs[r])
		begin
			name = $sformatf("record %0d %c", r, recs[r].kind);
			case (recs[r].kind)
				"C": apply_config(name, recs[r]);
				"P": run_cycle(name, 1'b0, 1'b1, '0, '0, '0, '0);
				"W": repeat (recs[r].cnt) run_cycle(name, 1'b0, 1'b0, '0, '0, '0, '0);
				"S": run_cycle(name, 1'b1, 1'b0, recs[r].user, recs[r].rx, recs[r].addr,
					recs[r].en);
				default: ;
			endcase
		end
		sva_fails = i_dut.i_sva.fail_cnt;
		total     = err_addr + err_en + err_data + err_cb + err_ping + err_other + sva_fails;
		$display("Errors: addr %0d en %0d data %0d report %0d ping %0d other %0d assert %0d",
			err_addr, err_en, err_data, err_cb, err_ping, err_other, sva_fails);
		if (total == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Run limit scales with the number of records
	initial
	begin : watchdog
		cycle_cnt = 0;
		wait (limit_set);
		while (cycle_cnt < cycle_limit)
		begin
			@(posedge core_clk);
			cycle_cnt++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycle_limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sim/drm_input_vectors.txt
# C user e0 e1 e0_num layer qm | P slot start | W idle_cycles
# S user rx expected_addr expected_en
C 0 0003 0002 01 0 2
C 1 0004 0020 00 1 2
C 2 0008 0010 00 1 1
C 3 0008 0008 00 1 4
C 4 0008 0008 00 1 6
C 5 0008 0008 00 1 8
C 6 0008 0008 00 1 3
C 7 0020 0020 01 0 0
P
W 12
# user 0 ends an E0 block, then an E1 block
S 0 0123456789abcdef00112233 000 0001
S 0 fedcba9876543210a5a5a5a5 000 0002
S 0 5a5a5a5a0f0f0f0fc3c3c3c3 000 0004
S 0 0000ffff0000ffff0000ffff 000 0008
S 0 13579bdf2468ace0deadbeef 400 0001
S 0 89abcdef0123456776543210 400 0002
S 0 0123456789abcdef00112233 400 0004
S 0 fedcba9876543210a5a5a5a5 000 0001
# two-layer users, qm 2 1 4 6 8 3
S 1 5a5a5a5a0f0f0f0fc3c3c3c3 001 0003
S 1 0000ffff0000ffff0000ffff 001 000c
S 1 13579bdf2468ace0deadbeef 001 0030
S 2 89abcdef0123456776543210 004 0003
S 3 0123456789abcdef00112233 006 0003
S 3 fedcba9876543210a5a5a5a5 006 000c
S 4 5a5a5a5a0f0f0f0fc3c3c3c3 007 0003
S 5 0000ffff0000ffff0000ffff 008 0003
S 6 13579bdf2468ace0deadbeef 009 0003
# invalid user indices
S 8 89abcdef0123456776543210 7ff 0000
S f 0123456789abcdef00112233 7ff 0000
# user 7 single layer wraps into the next row
S 7 fedcba9876543210a5a5a5a5 00a 0001
S 7 5a5a5a5a0f0f0f0fc3c3c3c3 00a 0002
S 7 0000ffff0000ffff0000ffff 00a 0004
S 7 13579bdf2468ace0deadbeef 00a 0008
S 7 89abcdef0123456776543210 00a 0010
S 7 0123456789abcdef00112233 00a 0020
S 7 fedcba9876543210a5a5a5a5 00a 0040
S 7 5a5a5a5a0f0f0f0fc3c3c3c3 00a 0080
S 7 0000ffff0000ffff0000ffff 00a 0100
S 7 13579bdf2468ace0deadbeef 00a 0200
S 7 89abcdef0123456776543210 00a 0400
S 7 0123456789abcdef00112233 00a 0800
S 7 fedcba9876543210a5a5a5a5 00a 1000
S 7 5a5a5a5a0f0f0f0fc3c3c3c3 00a 2000
S 7 0000ffff0000ffff0000ffff 00a 4000
S 7 13579bdf2468ace0deadbeef 00a 8000
S 7 89abcdef0123456776543210 00b 0001
# user 0 leaves the slot with ping-pong set
S 0 0123456789abcdef00112233 000 0002
S 0 fedcba9876543210a5a5a5a5 000 0004
W 2
P
W 12
S 0 5a5a5a5a0f0f0f0fc3c3c3c3 400 0001
S 0 0000ffff0000ffff0000ffff 400 0002
S 0 13579bdf2468ace0deadbeef 400 0004
S 0 89abcdef0123456776543210 400 0008
S 1 0123456789abcdef00112233 001 0003
W 3

//--- verilog.f
+incdir+design
design/drm_pkg.sv
design/drm_start_calc.sv
design/drm_user_track.sv
design/drm_write_port.sv
design/drm_input_writer.sv
sim/drm_input_writer_sva.sv
sim/tb_drm_input_writer.sv

//--- Makefile
# Verilator simulation of the input writer

VERILATOR ?= verilator
TOP       ?= tb_drm_input_writer
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
